/* verilog/gat_sm_pkg.sv */
package gat_sm_pkg;

  // ====================
  // Widths
  // ====================

  // Coefficient exponent, e in 0..15
  parameter int COEF_W  = 4;

  // Node count and node index, 1..15 nodes per subgraph
  parameter int NODE_W  = 4;

  // Sum of up to 15 terms of at most 2^15
  parameter int SUM_W   = 20;

  // Unsigned Q1.15, 1.0 is 0x8000
  parameter int ALPHA_W = 16;

  // ====================
  // Bundles
  // ====================

  // One input beat
  typedef struct packed {
    logic [NODE_W-1:0] num_node;
    logic [COEF_W-1:0] coef;
  } coef_beat_t;

  // Divisor FIFO entry, one per subgraph
  typedef struct packed {
    logic [NODE_W-1:0] num_node;
    logic [SUM_W-1:0]  sum;
  } dvsr_word_t;

  // Operand pair for the divider
  typedef struct packed {
    logic [SUM_W-1:0] dividend;
    logic [SUM_W-1:0] divisor;
  } div_in_t;

endpackage

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] din,
  input  logic              wr_en,
  input  logic              rd_en,
  output logic [DATA_W-1:0] dout,
  output logic              full,
  output logic              empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_wr;
  logic              do_rd;

  // Pointer wrap for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;
  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // First-word fall-through
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* verilog/coef_receiver.sv */
`timescale 1ns/1ps

module coef_receiver (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_req,
  input  gat_sm_pkg::coef_beat_t in_beat,
  input  logic                   beat_ready,
  output logic                   in_ack,
  output logic                   beat_valid,
  output gat_sm_pkg::coef_beat_t beat
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_HOLD,
    S_ACK,
    S_RELEASE
  } state_t;

  state_t state;
  logic   slot_free;
  logic   load;

  // Holding register is free once its beat moves downstream
  assign slot_free = !beat_valid || beat_ready;
  assign load      = in_req && slot_free && ((state == S_IDLE) || (state == S_HOLD));

  always_ff @(posedge clk) begin
    if (load) begin
      beat <= in_beat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      in_ack     <= 1'b0;
      beat_valid <= 1'b0;
    end else begin
      if (load) begin
        beat_valid <= 1'b1;
      end else if (beat_ready) begin
        beat_valid <= 1'b0;
      end

      case (state)
        S_IDLE: begin
          if (in_req) begin
            state  <= slot_free ? S_ACK : S_HOLD;
            in_ack <= slot_free;
          end
        end
        // Request seen, previous beat still waiting downstream
        S_HOLD: begin
          if (slot_free) begin
            state  <= S_ACK;
            in_ack <= 1'b1;
          end
        end
        S_ACK: begin
          if (!in_req) begin
            state  <= S_RELEASE;
            in_ack <= 1'b0;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

/* verilog/softmax.sv */
`timescale 1ns/1ps

module softmax #(
  parameter int DIVD_DEPTH = 16,
  parameter int DVSR_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   beat_valid,
  input  gat_sm_pkg::coef_beat_t beat,
  input  logic                   div_en,
  output logic                   beat_ready,
  output logic                   div_vld,
  output gat_sm_pkg::div_in_t    div_in
);

  localparam int SUM_W  = gat_sm_pkg::SUM_W;
  localparam int NODE_W = gat_sm_pkg::NODE_W;

  // Input side
  logic                   beat_fire;
  logic                   last_beat;
  logic [SUM_W-1:0]       pow;
  logic [NODE_W-1:0]      in_cnt;
  logic [SUM_W-1:0]       sum_acc;
  logic                   close_pend;
  gat_sm_pkg::dvsr_word_t close_word;

  // FIFO ports
  logic [SUM_W-1:0]       divd_dout;
  logic                   divd_full;
  logic                   divd_empty;
  logic                   divd_rd;
  gat_sm_pkg::dvsr_word_t dvsr_head;
  logic                   dvsr_full;
  logic                   dvsr_empty;
  logic                   dvsr_rd;

  // Output side
  logic [NODE_W-1:0]      out_cnt;
  logic [NODE_W-1:0]      cur_num;
  logic [SUM_W-1:0]       cur_sum;
  logic [NODE_W-1:0]      num_sel;
  logic                   need_dvsr;
  logic                   issue;

  // ====================
  // Exponent and sum
  // ====================

  assign pow = SUM_W'(1) << beat.coef;

  // Stall one cycle behind a closing beat so the divisor write sees a true full flag
  assign beat_ready = !divd_full && !dvsr_full && !close_pend;
  assign beat_fire  = beat_valid && beat_ready;
  assign last_beat  = (in_cnt == beat.num_node - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_cnt     <= '0;
      sum_acc    <= '0;
      close_pend <= 1'b0;
    end else begin
      close_pend <= beat_fire && last_beat;
      if (beat_fire) begin
        if (last_beat) begin
          in_cnt  <= '0;
          sum_acc <= '0;
        end else begin
          in_cnt  <= in_cnt + 1'b1;
          sum_acc <= sum_acc + pow;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_fire && last_beat) begin
      close_word.num_node <= beat.num_node;
      close_word.sum      <= sum_acc + pow;
    end
  end

  sync_fifo #(
    .DATA_W (SUM_W),
    .DEPTH  (DIVD_DEPTH)
  ) u_divd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (pow),
    .wr_en (beat_fire),
    .rd_en (divd_rd),
    .dout  (divd_dout),
    .full  (divd_full),
    .empty (divd_empty)
  );

  sync_fifo #(
    .DATA_W ($bits(gat_sm_pkg::dvsr_word_t)),
    .DEPTH  (DVSR_DEPTH)
  ) u_dvsr_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (close_word),
    .wr_en (close_pend),
    .rd_en (dvsr_rd),
    .dout  (dvsr_head),
    .full  (dvsr_full),
    .empty (dvsr_empty)
  );

  // ====================
  // Divider feed
  // ====================

  // New divisor needed at the first node of each subgraph
  assign need_dvsr = (out_cnt == '0);
  assign num_sel   = need_dvsr ? dvsr_head.num_node : cur_num;
  assign issue     = div_en && !divd_empty && (!need_dvsr || !dvsr_empty);
  assign divd_rd   = issue;
  assign dvsr_rd   = issue && need_dvsr;

  assign div_vld         = issue;
  assign div_in.dividend = divd_dout;
  assign div_in.divisor  = need_dvsr ? dvsr_head.sum : cur_sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt <= '0;
    end else if (issue) begin
      out_cnt <= (out_cnt == num_sel - 1'b1) ? '0 : out_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dvsr_rd) begin
      cur_num <= dvsr_head.num_node;
      cur_sum <= dvsr_head.sum;
    end
  end

endmodule

/* verilog/fxp_div_pipe.sv */
`timescale 1ns/1ps

module fxp_div_pipe (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          div_vld,
  input  gat_sm_pkg::div_in_t           div_in,
  input  logic                          div_en,
  output logic                          out_vld,
  output logic [gat_sm_pkg::ALPHA_W-1:0] out_alpha
);

  localparam int SUM_W   = gat_sm_pkg::SUM_W;
  localparam int ALPHA_W = gat_sm_pkg::ALPHA_W;

  // Stage k holds the remainder after quotient bit ALPHA_W-1-k
  // The last stage passes on only its quotient and valid bit
  logic [SUM_W-1:0]   rem_q  [ALPHA_W-1];
  logic [SUM_W-1:0]   dvsr_q [ALPHA_W-1];
  logic [ALPHA_W-1:0] quo_q  [ALPHA_W];
  logic               vld_q  [ALPHA_W];

  for (genvar k = 0; k < ALPHA_W; k++) begin : g_stage
    logic [SUM_W-1:0]   rem_in;
    logic [SUM_W-1:0]   dvsr_in;
    logic [ALPHA_W-1:0] quo_in;
    logic               vld_in;
    logic               nbit;
    logic [SUM_W:0]     shifted;
    logic [SUM_W:0]     diff;
    logic               ge;

    // Numerator is dividend << 15 and only its lsb is shifted in at stage 0
    if (k == 0) begin : g_first
      assign rem_in  = div_in.dividend >> 1;
      assign nbit    = div_in.dividend[0];
      assign dvsr_in = div_in.divisor;
      assign quo_in  = '0;
      assign vld_in  = div_vld;
    end else begin : g_next
      assign rem_in  = rem_q[k-1];
      assign nbit    = 1'b0;
      assign dvsr_in = dvsr_q[k-1];
      assign quo_in  = quo_q[k-1];
      assign vld_in  = vld_q[k-1];
    end

    assign shifted = {rem_in, nbit};
    assign diff    = shifted - {1'b0, dvsr_in};
    assign ge      = (shifted >= {1'b0, dvsr_in});

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vld_q[k] <= 1'b0;
      end else if (div_en) begin
        vld_q[k] <= vld_in;
      end
    end

    always_ff @(posedge clk) begin
      if (div_en) begin
        quo_q[k] <= {quo_in[ALPHA_W-2:0], ge};
      end
    end

    if (k < ALPHA_W - 1) begin : g_carry
      always_ff @(posedge clk) begin
        if (div_en) begin
          rem_q[k]  <= ge ? diff[SUM_W-1:0] : shifted[SUM_W-1:0];
          dvsr_q[k] <= dvsr_in;
        end
      end
    end
  end

  // Output register with the truncated Q1.15 quotient
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else if (div_en) begin
      out_vld <= vld_q[ALPHA_W-1];
    end
  end

  always_ff @(posedge clk) begin
    if (div_en) begin
      out_alpha <= quo_q[ALPHA_W-1];
    end
  end

endmodule

/* verilog/alpha_sender.sv */
`timescale 1ns/1ps

module alpha_sender (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           out_vld,
  input  logic [gat_sm_pkg::ALPHA_W-1:0] out_alpha_in,
  input  logic                           out_ack,
  output logic                           out_req,
  output logic [gat_sm_pkg::ALPHA_W-1:0] out_alpha,
  output logic                           ready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_RELEASE
  } state_t;

  state_t state;

  // Buffer empty only in idle, this also freezes the divider
  assign ready = (state == S_IDLE);

  always_ff @(posedge clk) begin
    if (ready && out_vld) begin
      out_alpha <= out_alpha_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      out_req <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (out_vld) begin
            state   <= S_REQ;
            out_req <= 1'b1;
          end
        end
        S_REQ: begin
          if (out_ack) begin
            state   <= S_RELEASE;
            out_req <= 1'b0;
          end
        end
        // Wait for the return to zero
        default: begin
          if (!out_ack) begin
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* verilog/gat_softmax_top.sv */
`timescale 1ns/1ps

module gat_softmax_top #(
  parameter int DIVD_DEPTH = 16,
  parameter int DVSR_DEPTH = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           in_req,
  input  gat_sm_pkg::coef_beat_t         in_beat,
  input  logic                           out_ack,
  output logic                           in_ack,
  output logic                           out_req,
  output logic [gat_sm_pkg::ALPHA_W-1:0] out_alpha
);

  logic                           beat_valid;
  logic                           beat_ready;
  gat_sm_pkg::coef_beat_t         beat;
  logic                           div_vld;
  gat_sm_pkg::div_in_t            div_in;
  logic                           div_en;
  logic                           div_out_vld;
  logic [gat_sm_pkg::ALPHA_W-1:0] div_alpha;

  coef_receiver u_coef_receiver (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req     (in_req),
    .in_beat    (in_beat),
    .beat_ready (beat_ready),
    .in_ack     (in_ack),
    .beat_valid (beat_valid),
    .beat       (beat)
  );

  softmax #(
    .DIVD_DEPTH (DIVD_DEPTH),
    .DVSR_DEPTH (DVSR_DEPTH)
  ) u_softmax (
    .clk        (clk),
    .rst_n      (rst_n),
    .beat_valid (beat_valid),
    .beat       (beat),
    .div_en     (div_en),
    .beat_ready (beat_ready),
    .div_vld    (div_vld),
    .div_in     (div_in)
  );

  fxp_div_pipe u_fxp_div_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .div_vld   (div_vld),
    .div_in    (div_in),
    .div_en    (div_en),
    .out_vld   (div_out_vld),
    .out_alpha (div_alpha)
  );

  alpha_sender u_alpha_sender (
    .clk          (clk),
    .rst_n        (rst_n),
    .out_vld      (div_out_vld),
    .out_alpha_in (div_alpha),
    .out_ack      (out_ack),
    .out_req      (out_req),
    .out_alpha    (out_alpha),
    .ready        (div_en)
  );

endmodule

/* tests/tb_gat_softmax_tasks.svh */
`ifndef TB_GAT_SOFTMAX_TASKS_SVH
`define TB_GAT_SOFTMAX_TASKS_SVH

// ====================
// Helpers
// ====================

function automatic logic [31:0] lcg_step(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("ERROR at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
  end
endtask

// floor(2^e * 32768 / sum of 2^e)
function automatic logic [ALPHA_W-1:0] model_alpha(input logic [COEF_W-1:0] e,
                                                   input longint sum);
  longint num;
  num = longint'(1) << e;
  return ALPHA_W'((num * 32768) / sum);
endfunction

// Four-phase input master, called on a falling edge
task automatic send_beat(input int num, input logic [COEF_W-1:0] coef);
  in_beat.num_node = num[NODE_W-1:0];
  in_beat.coef     = coef;
  in_req           = 1'b1;
  @(negedge clk);
  while (!in_ack) @(negedge clk);
  in_req = 1'b0;
  @(negedge clk);
  while (in_ack) @(negedge clk);
endtask

task automatic send_subgraph();
  int i;
  for (i = 0; i < sub_coefs.size(); i++) begin
    send_beat(sub_coefs.size(), sub_coefs[i]);
  end
  beats_sent += sub_coefs.size();
endtask

task automatic expect_subgraph();
  longint sum;
  int     i;
  sum = 0;
  for (i = 0; i < sub_coefs.size(); i++) begin
    sum += longint'(1) << sub_coefs[i];
  end
  for (i = 0; i < sub_coefs.size(); i++) begin
    exp_q.push_back(model_alpha(sub_coefs[i], sum));
  end
endtask

task automatic fill_random(input int n);
  int i;
  sub_coefs.delete();
  for (i = 0; i < n; i++) begin
    stim_seed = lcg_step(stim_seed);
    sub_coefs.push_back(stim_seed[27:24]);
  end
endtask

function automatic int random_size();
  stim_seed = lcg_step(stim_seed);
  return int'(stim_seed[23:16]) % 15 + 1;
endfunction

// Output side slave, with an optional random ack delay
task automatic collect_alphas();
  int delay;
  forever begin
    @(negedge clk);
    if (out_req) begin
      got_q.push_back(out_alpha);
      delay_seed = lcg_step(delay_seed);
      delay      = int'(delay_seed[23:16]) % (ack_delay_max + 1);
      repeat (delay) @(negedge clk);
      out_ack = 1'b1;
      @(negedge clk);
      while (out_req) @(negedge clk);
      out_ack = 1'b0;
    end
  end
endtask

task automatic compare_results();
  int waited;
  int i;
  waited = 0;
  while (got_q.size() < exp_q.size() && waited < DRAIN_LIMIT) begin
    @(negedge clk);
    waited++;
  end
  // Quiet period catches duplicated results
  repeat (QUIET_CYCLES) @(negedge clk);
  check_value("out_count", got_q.size(), beats_sent);
  for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
    check_value("out_alpha", 32'(got_q[i]), 32'(exp_q[i]));
  end
  exp_q.delete();
  got_q.delete();
  beats_sent = 0;
endtask

task automatic finish_test(input string name, input int errs_before);
  int errs;
  errs = err_cnt - errs_before;
  test_cnt++;
  if (errs != 0) begin
    test_fail_cnt++;
  end
  $display("Test %-18s done at %0t with %0d error(s)", name, $time, errs);
endtask

// ====================
// Tests
// ====================

task automatic test_reset_idle();
  int errs;
  errs = err_cnt;
  repeat (30) begin
    @(negedge clk);
    check_value("in_ack", 32'(in_ack), 0);
    check_value("out_req", 32'(out_req), 0);
  end
  finish_test("reset_idle", errs);
endtask

task automatic test_four_nodes();
  int errs;
  int i;
  errs = err_cnt;
  sub_coefs.delete();
  for (i = 0; i < 4; i++) begin
    sub_coefs.push_back(i[COEF_W-1:0]);
  end
  expect_subgraph();
  send_subgraph();
  compare_results();
  finish_test("four_nodes", errs);
endtask

task automatic test_single_node();
  logic [COEF_W-1:0] picks[3] = '{4'd0, 4'd9, 4'd15};
  int                errs;
  int                i;
  errs = err_cnt;
  for (i = 0; i < 3; i++) begin
    sub_coefs.delete();
    sub_coefs.push_back(picks[i]);
    exp_q.push_back(16'h8000);
    send_subgraph();
  end
  compare_results();
  finish_test("single_node", errs);
endtask

task automatic test_back_to_back();
  int sizes[3] = '{2, 15, 5};
  int errs;
  int i;
  errs = err_cnt;
  for (i = 0; i < 3; i++) begin
    fill_random(sizes[i]);
    expect_subgraph();
    send_subgraph();
  end
  compare_results();
  finish_test("back_to_back", errs);
endtask

task automatic test_back_pressure();
  int sizes[3] = '{6, 12, 3};
  int errs;
  int i;
  errs          = err_cnt;
  ack_delay_max = 6;
  for (i = 0; i < 3; i++) begin
    fill_random(sizes[i]);
    expect_subgraph();
    send_subgraph();
  end
  compare_results();
  ack_delay_max = 0;
  finish_test("back_pressure", errs);
endtask

task automatic test_random_subgraphs();
  int errs;
  int i;
  errs = err_cnt;
  for (i = 0; i < 20; i++) begin
    fill_random(random_size());
    expect_subgraph();
    send_subgraph();
  end
  compare_results();
  finish_test("random_subgraphs", errs);
endtask

`endif

/* tests/tb_gat_softmax.sv */
`timescale 1ns/1ps

module tb_gat_softmax;

  localparam int COEF_W  = gat_sm_pkg::COEF_W;
  localparam int NODE_W  = gat_sm_pkg::NODE_W;
  localparam int ALPHA_W = gat_sm_pkg::ALPHA_W;

  // About 210 beats, up to 24 cycles each with handshakes and ack delays, times four
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int DRAIN_LIMIT    = 2000;
  localparam int QUIET_CYCLES   = 60;

  logic                   clk;
  logic                   rst_n;
  logic                   in_req;
  gat_sm_pkg::coef_beat_t in_beat;
  logic                   out_ack;
  logic                   in_ack;
  logic                   out_req;
  logic [ALPHA_W-1:0]     out_alpha;

  // Scoreboard
  logic [COEF_W-1:0]  sub_coefs[$];
  logic [ALPHA_W-1:0] exp_q[$];
  logic [ALPHA_W-1:0] got_q[$];
  int                 beats_sent;
  int                 ack_delay_max;
  logic [31:0]        stim_seed;
  logic [31:0]        delay_seed;

  // Counters
  int cycle_cnt = 0;
  int err_cnt;
  int check_cnt;
  int test_cnt;
  int test_fail_cnt;

  gat_softmax_top #(
    .DIVD_DEPTH (16),
    .DVSR_DEPTH (4)
  ) u_gat_softmax_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_req    (in_req),
    .in_beat   (in_beat),
    .out_ack   (out_ack),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .out_alpha (out_alpha)
  );

  `include "tb_gat_softmax_tasks.svh"

  // ====================
  // Clock and run limit
  // ====================

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ====================
  // Test sequence
  // ====================

  initial begin
    rst_n         = 1'b0;
    in_req        = 1'b0;
    in_beat       = '0;
    out_ack       = 1'b0;
    ack_delay_max = 0;
    beats_sent    = 0;
    stim_seed     = 32'ha62f;
    delay_seed    = 32'ha62f;
    err_cnt       = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;

    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    fork
      collect_alphas();
    join_none

    test_reset_idle();
    test_four_nodes();
    test_single_node();
    test_back_to_back();
    test_back_pressure();
    test_random_subgraphs();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+tests
verilog/gat_sm_pkg.sv
verilog/sync_fifo.sv
verilog/coef_receiver.sv
verilog/softmax.sv
verilog/fxp_div_pipe.sv
verilog/alpha_sender.sv
verilog/gat_softmax_top.sv
tests/tb_gat_softmax.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_gat_softmax -f tb.f -o tb_sim

output=$(./obj_dir/tb_sim)
echo "$output"

if echo "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
